//--- vlog.f
logic/exec_pkg.sv
logic/exec_issue_if.sv
logic/issue_buffer.sv
logic/branch_unit.sv
logic/int_alu.sv
logic/exec_stage.sv
logic/exec_top.sv
bench/exec_clkgen.sv
bench/exec_checker.sv
bench/exec_assertions.sv
bench/exec_tb.sv

//--- Bender.yml
package:
  name: exec_slice

sources:
  - target: rtl
    files:
      - logic/exec_pkg.sv
      - logic/exec_issue_if.sv
      - logic/issue_buffer.sv
      - logic/branch_unit.sv
      - logic/int_alu.sv
      - logic/exec_stage.sv
      - logic/exec_top.sv
  - target: test
    files:
      - bench/exec_clkgen.sv
      - bench/exec_checker.sv
      - bench/exec_assertions.sv
      - bench/exec_tb.sv

//--- bench/exec_tb.sv
// exec_tb: stimulus table, input driver, random output back-pressure, timeout, final verdict
`timescale 1ns/1ps

module exec_tb import exec_pkg::*; ();

    localparam int NUM_TESTS      = 20;
    localparam int STALL_AT       = 8;   // table index that starts the long stall
    localparam int STALL_CYCLES   = 8;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * (2 + STALL_CYCLES) + 50;

    localparam bus64_t MINUS1  = '1;
    localparam bus64_t MINUS5  = -64'sd5;
    localparam bus64_t IMM_M16 = -64'sd16;

    typedef struct {
        exec_op_t op;
        addr_pc_t pc;
        bus64_t   rs1;
        bus64_t   rs2;
        bus64_t   imm;
        reg_idx_t rd;
        bit       drain;   // wait for an empty pipeline first
        string    name;
    } stim_t;

    logic        clk_i;
    logic        arst_n_i;
    logic        in_valid_i;
    logic        in_ready_o;
    exec_op_t    in_op_i;
    addr_pc_t    in_pc_i;
    bus64_t      in_rs1_i;
    bus64_t      in_rs2_i;
    bus64_t      in_imm_i;
    reg_idx_t    in_rd_i;
    logic        out_valid_o;
    logic        out_ready_i;
    reg_idx_t    out_rd_o;
    logic        out_we_o;
    bus64_t      out_wb_data_o;
    logic        out_taken_o;
    addr_pc_t    out_next_pc_o;
    int          pending;           // results still owed, from the checker
    int          done;              // results compared so far
    stim_t       stim_q[$];
    int          issue_idx  = 0;
    int          stall_left = 0;
    bit          stall_done = 1'b0;
    int          cycles     = 0;
    logic [31:0] lcg_state  = 32'h828e1e9d;

    exec_clkgen i_clkgen (.clk_o(clk_i), .arst_n_o(arst_n_i));

    exec_top i_exec_top (.*);

    exec_checker i_checker (
        .clk_i (clk_i), .arst_n_i (arst_n_i),
        .in_valid_i (in_valid_i), .in_ready_i (in_ready_o), .in_op_i (in_op_i),
        .in_pc_i (in_pc_i), .in_rs1_i (in_rs1_i), .in_rs2_i (in_rs2_i),
        .in_imm_i (in_imm_i), .in_rd_i (in_rd_i),
        .out_valid_i (out_valid_o), .out_ready_i (out_ready_i), .out_rd_i (out_rd_o),
        .out_we_i (out_we_o), .out_wb_data_i (out_wb_data_o),
        .out_taken_i (out_taken_o), .out_next_pc_i (out_next_pc_o),
        .pending_o (pending), .done_o (done)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic add_entry(input exec_op_t op, input addr_pc_t pc, input bus64_t rs1,
                             input bus64_t rs2, input bus64_t imm, input reg_idx_t rd,
                             input bit drain, input string name);
        stim_t s;
        s = '{op: op, pc: pc, rs1: rs1, rs2: rs2, imm: imm, rd: rd, drain: drain, name: name};
        stim_q.push_back(s);
    endtask

    task automatic build_table();
        add_entry(BEQ,  40'h1000, 64'd5,    64'd5,    64'h40,  5'd1,  1'b0, "beq_t");
        add_entry(BEQ,  40'h1004, 64'd5,    64'd6,    64'h40,  5'd2,  1'b0, "beq_nt");
        add_entry(BNE,  40'h2000, 64'd1,    64'd2,    IMM_M16, 5'd3,  1'b0, "bne_t");
        add_entry(BNE,  40'h2004, 64'd7,    64'd7,    IMM_M16, 5'd4,  1'b0, "bne_nt");
        add_entry(BLT,  40'h2100, MINUS1,   64'd1,    64'h20,  5'd11, 1'b0, "blt_neg_t");
        add_entry(BLT,  40'h2104, 64'd1,    MINUS1,   64'h20,  5'd12, 1'b0, "blt_nt");
        add_entry(BGE,  40'h2200, 64'd1,    MINUS1,   64'h80,  5'd13, 1'b0, "bge_t");
        add_entry(BGE,  40'h2204, MINUS5,   64'd3,    64'h80,  5'd14, 1'b0, "bge_neg_nt");
        add_entry(BLTU, 40'h2300, MINUS1,   64'd1,    64'h10,  5'd15, 1'b0, "bltu_nt");
        add_entry(BLTU, 40'h2304, 64'd1,    MINUS1,   64'h10,  5'd16, 1'b0, "bltu_t");
        add_entry(BGEU, 40'h2400, MINUS1,   64'd1,    IMM_M16, 5'd17, 1'b0, "bgeu_t");
        add_entry(BGEU, 40'h2404, 64'd1,    MINUS1,   IMM_M16, 5'd18, 1'b0, "bgeu_nt");
        add_entry(JAL,  40'h3000, 64'd0,    64'd0,    64'h100, 5'd5,  1'b1, "jal");
        add_entry(JALR, 40'h3100, 64'h8001, 64'd0,    64'h10,  5'd6,  1'b0, "jalr_odd");
        add_entry(JAL,  40'h3200, 64'd0,    64'd0,    64'h40,  5'd0,  1'b0, "jal_x0");
        add_entry(ADD,  40'h4000, MINUS1,   64'd2,    64'd0,   5'd7,  1'b1, "add_wrap");
        add_entry(SUB,  40'h4004, 64'd0,    64'd1,    64'd0,   5'd8,  1'b0, "sub_wrap");
        add_entry(SLT,  40'h4008, MINUS1,   64'd1,    64'd0,   5'd9,  1'b0, "slt");
        add_entry(SLTU, 40'h400c, MINUS1,   64'd1,    64'd0,   5'd10, 1'b0, "sltu");
        add_entry(AND,  40'h4010, MINUS1,   64'hf0f0, 64'd0,   5'd0,  1'b0, "and_x0");
    endtask

    // hold one entry on the inputs until the handshake edge
    task automatic apply_entry(input stim_t s);
        bit accepted;
        if (s.drain) begin
            while (pending != 0) begin
                @(posedge clk_i);
                #0.5;
            end
        end
        in_valid_i = 1'b1;
        in_op_i    = s.op;
        in_pc_i    = s.pc;
        in_rs1_i   = s.rs1;
        in_rs2_i   = s.rs2;
        in_imm_i   = s.imm;
        in_rd_i    = s.rd;
        i_checker.note_name(s.name);
        accepted = 1'b0;
        while (!accepted) begin
            accepted = in_ready_o;   // registered, steady until the edge
            @(posedge clk_i);
            #0.5;
        end
        in_valid_i = 1'b0;
    endtask

    // ~70 percent ready, plus one long stall
    always begin
        @(posedge clk_i);
        #0.5;
        lcg_state = lcg_next(lcg_state);
        if (!arst_n_i) begin
            out_ready_i = 1'b0;
        end else if (stall_left > 0) begin
            out_ready_i = 1'b0;
            stall_left  = stall_left - 1;
        end else if (!stall_done && issue_idx >= STALL_AT) begin
            stall_done  = 1'b1;
            stall_left  = STALL_CYCLES - 1;
            out_ready_i = 1'b0;
        end else begin
            out_ready_i = (lcg_state[31:24] < 8'd179);
        end
    end

    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: outputs stopped before all tests completed");
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        int n;
        int total_errors;
        in_valid_i  = 1'b0;
        in_op_i     = NOP;
        in_pc_i     = '0;
        in_rs1_i    = '0;
        in_rs2_i    = '0;
        in_imm_i    = '0;
        in_rd_i     = '0;
        out_ready_i = 1'b0;
        build_table();
        wait (arst_n_i);
        @(posedge clk_i);
        #0.5;
        for (n = 0; n < NUM_TESTS; n++) begin
            issue_idx = n;
            apply_entry(stim_q[n]);
        end
        issue_idx = NUM_TESTS;
        while (done != NUM_TESTS) begin
            @(posedge clk_i);
            #0.5;
        end
        i_checker.close_run(total_errors);
        total_errors = total_errors + i_exec_top.i_assertions.fail_count;  // bound checks
        if (total_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- bench/exec_assertions.sv
// exec_assertions: reset, output stall and buffer-full assertions, bound into exec_top
`timescale 1ns/1ps

module exec_assertions import exec_pkg::*; (
    input logic     clk_i,
    input logic     arst_n_i,
    input logic     in_valid_i,
    input logic     in_ready_i,
    input logic     out_valid_i,
    input logic     out_ready_i,
    input reg_idx_t out_rd_i,
    input logic     out_we_i,
    input bus64_t   out_wb_data_i,
    input logic     out_taken_i,
    input addr_pc_t out_next_pc_i
);

    logic [2:0] in_flight_q;     // accepted minus delivered, seen from the ports
    int         fail_count = 0;  // failed assertions so far

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            in_flight_q <= '0;
        end else begin
            in_flight_q <= in_flight_q + 3'(in_valid_i & in_ready_i)
                                       - 3'(out_valid_i & out_ready_i);
        end
    end

    a_reset_quiet: assert property (@(posedge clk_i) !arst_n_i |-> !out_valid_i)
        else begin
            fail_count++;
            $error("out_valid_o high during reset");
        end

    // stalled result keeps valid and payload
    a_stall_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        out_valid_i && !out_ready_i |=> out_valid_i)
        else begin
            fail_count++;
            $error("out_valid_o dropped while stalled");
        end

    a_stall_data: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        out_valid_i && !out_ready_i |=>
            $stable({out_rd_i, out_we_i, out_wb_data_i, out_taken_i, out_next_pc_i}))
        else begin
            fail_count++;
            $error("output payload changed while stalled");
        end

    // two held in the buffer plus one in the output register
    a_full_only: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !in_ready_i |-> (in_flight_q == 3'd3))
        else begin
            fail_count++;
            $error("in_ready_o low without two items held in the buffer");
        end

endmodule

bind exec_top exec_assertions i_assertions (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .in_valid_i    (in_valid_i),
    .in_ready_i    (in_ready_o),
    .out_valid_i   (out_valid_o),
    .out_ready_i   (out_ready_i),
    .out_rd_i      (out_rd_o),
    .out_we_i      (out_we_o),
    .out_wb_data_i (out_wb_data_o),
    .out_taken_i   (out_taken_o),
    .out_next_pc_i (out_next_pc_o)
);

//--- bench/exec_checker.sv
// exec_checker: reference model, expected-result queue, output compare, latency and fill checks
`timescale 1ns/1ps

module exec_checker import exec_pkg::*; (
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     in_valid_i,
    input  logic     in_ready_i,
    input  exec_op_t in_op_i,
    input  addr_pc_t in_pc_i,
    input  bus64_t   in_rs1_i,
    input  bus64_t   in_rs2_i,
    input  bus64_t   in_imm_i,
    input  reg_idx_t in_rd_i,
    input  logic     out_valid_i,
    input  logic     out_ready_i,
    input  reg_idx_t out_rd_i,
    input  logic     out_we_i,
    input  bus64_t   out_wb_data_i,
    input  logic     out_taken_i,
    input  addr_pc_t out_next_pc_i,
    output int       pending_o,
    output int       done_o
);

    typedef struct packed {
        reg_idx_t rd;
        logic     we;
        bus64_t   wb;
        logic     taken;
        addr_pc_t next_pc;
    } result_t;

    result_t exp_q[$];      // expected results, issue order
    string   names_q[$];    // test names, same order
    int      cycle      = 0;
    int      done       = 0;
    int      errors     = 0;
    int      full_seen  = 0;  // cycles with the buffer full
    int      lat_checks = 0;
    bit      lat_armed  = 1'b0;
    int      lat_start  = 0;

    assign pending_o = exp_q.size();
    assign done_o    = done;

    task automatic note_name(input string name);
        names_q.push_back(name);
    endtask

    // expected result straight from the branch and alu rules
    function automatic result_t model(input exec_req_t r);
        result_t  e;
        addr_pc_t seq_pc;
        addr_pc_t dest;
        bus64_t   sum;
        logic     jump;
        logic     alu;
        seq_pc  = r.pc + 40'd4;
        sum     = r.rs1 + r.imm;
        dest    = (r.op == JALR) ? {sum[PC_W-1:1], 1'b0} : r.pc + r.imm[PC_W-1:0];
        jump    = 1'b0;
        alu     = 1'b1;      // cleared for everything not alu
        e.rd    = r.rd;
        e.taken = 1'b0;
        e.wb    = '0;
        case (r.op)
            JAL, JALR: jump = 1'b1;
            BEQ:  e.taken = (r.rs1 == r.rs2);
            BNE:  e.taken = (r.rs1 != r.rs2);
            BLT:  e.taken = ($signed(r.rs1) < $signed(r.rs2));
            BGE:  e.taken = ($signed(r.rs1) >= $signed(r.rs2));
            BLTU: e.taken = (r.rs1 < r.rs2);
            BGEU: e.taken = (r.rs1 >= r.rs2);
            ADD:  e.wb = r.rs1 + r.rs2;
            SUB:  e.wb = r.rs1 - r.rs2;
            AND:  e.wb = r.rs1 & r.rs2;
            OR:   e.wb = r.rs1 | r.rs2;
            XOR:  e.wb = r.rs1 ^ r.rs2;
            SLT:  e.wb = ($signed(r.rs1) < $signed(r.rs2)) ? 64'd1 : 64'd0;
            SLTU: e.wb = (r.rs1 < r.rs2) ? 64'd1 : 64'd0;
            default: ;
        endcase
        if (r.op inside {JAL, JALR, BEQ, BNE, BLT, BGE, BLTU, BGEU, NOP}) alu = 1'b0;
        if (jump) begin
            e.taken = 1'b1;
            e.wb    = {{(XLEN-PC_W){1'b0}}, seq_pc};  // link
        end
        e.we      = (jump || alu) && (r.rd != '0);
        e.next_pc = e.taken ? dest : seq_pc;
        return e;
    endfunction

    function automatic int field_check(input int idx, input string nm, input string field,
                                       input bus64_t expv, input bus64_t got);
        if (expv !== got) begin
            $display("Mismatch at %0t: test %0d (%s) %s expected %h got %h",
                     $time, idx, nm, field, expv, got);
            return 1;
        end
        return 0;
    endfunction

    always @(posedge clk_i) begin
        result_t   e;
        exec_req_t req;
        string     nm;
        int        bad;
        cycle = cycle + 1;
        if (arst_n_i) begin
            if (!in_ready_i) full_seen = full_seen + 1;
            // lone item must show up exactly two edges after acceptance
            if (lat_armed && cycle == lat_start + 1 && out_valid_i) begin
                $display("latency: result appeared one cycle after acceptance, too early");
                errors = errors + 1;
            end
            if (lat_armed && cycle == lat_start + 2) begin
                lat_armed  = 1'b0;
                lat_checks = lat_checks + 1;
                if (!out_valid_i) begin
                    $display("latency: result missing two cycles after acceptance");
                    errors = errors + 1;
                end
            end
            if (out_valid_i && out_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("unexpected result for rd %0d with nothing outstanding", out_rd_i);
                    errors = errors + 1;
                end else begin
                    e   = exp_q.pop_front();
                    nm  = (names_q.size() != 0) ? names_q.pop_front() : "unnamed";
                    bad = 0;
                    bad += field_check(done, nm, "out_rd_o", e.rd, out_rd_i);
                    bad += field_check(done, nm, "out_we_o", e.we, out_we_i);
                    bad += field_check(done, nm, "out_wb_data_o", e.wb, out_wb_data_i);
                    bad += field_check(done, nm, "out_taken_o", e.taken, out_taken_i);
                    bad += field_check(done, nm, "out_next_pc_o", e.next_pc, out_next_pc_i);
                    if (bad == 0) $display("test %0d %s: ok", done, nm);
                    else          $display("test %0d %s: %0d field(s) wrong", done, nm, bad);
                    errors = errors + bad;
                    done   = done + 1;
                end
            end
            if (in_valid_i && in_ready_i) begin
                req = '{op: in_op_i, pc: in_pc_i, rs1: in_rs1_i, rs2: in_rs2_i,
                        imm: in_imm_i, rd: in_rd_i};
                exp_q.push_back(model(req));
                if (exp_q.size() == 1) begin  // pipeline was empty
                    lat_armed = 1'b1;
                    lat_start = cycle;
                end
            end
        end
    end

    task automatic close_run(output int total_errors);
        if (exp_q.size() != 0) begin
            $display("%0d results never came out of the DUT", exp_q.size());
            errors = errors + 1;
        end
        if (full_seen == 0) begin
            $display("in_ready_o never dropped, the buffer never filled under back-pressure");
            errors = errors + 1;
        end
        if (lat_checks == 0) begin
            $display("no operation entered an empty pipeline, latency was never checked");
            errors = errors + 1;
        end
        $display("checker: %0d tests, %0d errors, %0d latency checks", done, errors, lat_checks);
        total_errors = errors;
    endtask

endmodule

//--- bench/exec_clkgen.sv
// exec_clkgen: 4 ns testbench clock and active-low reset held for two cycles
`timescale 1ns/1ps

module exec_clkgen (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o    = 1'b0;
        arst_n_o = 1'b0;              // in reset from time zero
        repeat (2) @(posedge clk_o);
        #0.5 arst_n_o = 1'b1;         // released just after the second edge
    end

    always #2 clk_o = ~clk_o;         // 4 ns period

endmodule

//--- logic/exec_top.sv
// exec_top: issue buffer feeding the execute stage, plain ports on both sides
`timescale 1ns/1ps

module exec_top import exec_pkg::*; (
    input  logic     clk_i,
    input  logic     arst_n_i,
    // issue side
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  exec_op_t in_op_i,
    input  addr_pc_t in_pc_i,
    input  bus64_t   in_rs1_i,
    input  bus64_t   in_rs2_i,
    input  bus64_t   in_imm_i,
    input  reg_idx_t in_rd_i,
    // result side
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output reg_idx_t out_rd_o,
    output logic     out_we_o,
    output bus64_t   out_wb_data_o,
    output logic     out_taken_o,
    output addr_pc_t out_next_pc_o
);

    exec_req_t    in_req;
    exec_issue_if issue ();  // buffer to stage

    assign in_req = '{op: in_op_i, pc: in_pc_i, rs1: in_rs1_i, rs2: in_rs2_i,
                      imm: in_imm_i, rd: in_rd_i};

    issue_buffer u_issue_buffer (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .in_valid_i (in_valid_i),
        .in_ready_o (in_ready_o),
        .in_req_i   (in_req),
        .issue      (issue.src)
    );

    exec_stage u_exec_stage (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .issue         (issue.dst),
        .out_valid_o   (out_valid_o),
        .out_ready_i   (out_ready_i),
        .out_rd_o      (out_rd_o),
        .out_we_o      (out_we_o),
        .out_wb_data_o (out_wb_data_o),
        .out_taken_o   (out_taken_o),
        .out_next_pc_o (out_next_pc_o)
    );

endmodule

//--- logic/exec_stage.sv
// exec_stage: branch unit and alu side by side, result select and output register
`timescale 1ns/1ps

module exec_stage import exec_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    exec_issue_if.dst issue,
    output logic      out_valid_o,
    input  logic      out_ready_i,
    output reg_idx_t  out_rd_o,
    output logic      out_we_o,
    output bus64_t    out_wb_data_o,
    output logic      out_taken_o,
    output addr_pc_t  out_next_pc_o
);

    logic     is_jump;
    logic     is_branch;
    logic     is_alu;
    logic     bu_taken;
    addr_pc_t bu_next_pc;
    bus64_t   bu_link;
    bus64_t   alu_result;
    logic     we_d;
    bus64_t   wb_data_d;
    logic     load;       // take a new result this edge

    // operation class
    always_comb begin
        is_jump   = 1'b0;
        is_branch = 1'b0;
        is_alu    = 1'b0;
        case (issue.req.op)
            JAL, JALR:                          is_jump   = 1'b1;
            BEQ, BNE, BLT, BGE, BLTU, BGEU:     is_branch = 1'b1;
            ADD, SUB, AND, OR, XOR, SLT, SLTU:  is_alu    = 1'b1;
            default:                            ;  // nop, nothing to do
        endcase
    end

    branch_unit u_branch_unit (
        .op_i      (issue.req.op),
        .pc_i      (issue.req.pc),
        .rs1_i     (issue.req.rs1),
        .rs2_i     (issue.req.rs2),
        .imm_i     (issue.req.imm),
        .taken_o   (bu_taken),
        .target_o  (),            // redirect not part of this slice
        .next_pc_o (bu_next_pc),  // pc+4 for anything not taken
        .link_o    (bu_link)
    );

    int_alu u_int_alu (
        .op_i     (issue.req.op),
        .a_i      (issue.req.rs1),
        .b_i      (issue.req.rs2),
        .result_o (alu_result)
    );

    // branches never write and carry zero data
    assign wb_data_d = is_jump ? bu_link : (is_alu ? alu_result : '0);
    assign we_d      = (is_jump | is_alu) & (issue.req.rd != '0);  // x0 stays zero

    // free slot when empty or draining this cycle
    assign issue.ready = ~out_valid_o | out_ready_i;
    assign load        = issue.valid & issue.ready;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_valid_o   <= 1'b0;
            out_rd_o      <= '0;
            out_we_o      <= 1'b0;
            out_wb_data_o <= '0;
            out_taken_o   <= 1'b0;
            out_next_pc_o <= '0;
        end else if (load) begin
            out_valid_o   <= 1'b1;
            out_rd_o      <= issue.req.rd;
            out_we_o      <= we_d;
            out_wb_data_o <= wb_data_d;
            out_taken_o   <= bu_taken & (is_jump | is_branch);
            out_next_pc_o <= bu_next_pc;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;  // drained, payload kept
        end
    end

endmodule

//--- logic/int_alu.sv
// int_alu: combinational integer alu for add, sub, logic ops and set-less-than
`timescale 1ns/1ps

module int_alu import exec_pkg::*; (
    input  exec_op_t op_i,
    input  bus64_t   a_i,
    input  bus64_t   b_i,
    output bus64_t   result_o
);

    logic lt_s;   // a < b signed
    logic lt_u;   // a < b unsigned

    assign lt_s = ($signed(a_i) < $signed(b_i));
    assign lt_u = (a_i < b_i);

    always_comb begin
        case (op_i)
            ADD: begin
                result_o = a_i + b_i;          // wraps at XLEN
            end
            SUB: begin
                result_o = a_i - b_i;
            end
            AND: begin
                result_o = a_i & b_i;
            end
            OR: begin
                result_o = a_i | b_i;
            end
            XOR: begin
                result_o = a_i ^ b_i;
            end
            SLT: begin
                result_o = {{(XLEN-1){1'b0}}, lt_s};
            end
            SLTU: begin
                result_o = {{(XLEN-1){1'b0}}, lt_u};
            end
            default: begin
                // branches, jumps, nop
                result_o = '0;
            end
        endcase
    end

endmodule

//--- logic/branch_unit.sv
// branch_unit: branch condition, jump/branch target, resolved next pc and link value
`timescale 1ns/1ps

module branch_unit import exec_pkg::*; (
    input  exec_op_t op_i,
    input  addr_pc_t pc_i,
    input  bus64_t   rs1_i,
    input  bus64_t   rs2_i,
    input  bus64_t   imm_i,
    output logic     taken_o,
    output addr_pc_t target_o,
    output addr_pc_t next_pc_o,
    output bus64_t   link_o
);

    logic     equal;
    logic     less;     // signed compare
    logic     less_u;   // unsigned compare
    addr_pc_t pc_plus4;
    bus64_t   jalr_sum;

    assign equal  = (rs1_i == rs2_i);
    assign less   = ($signed(rs1_i) < $signed(rs2_i));
    assign less_u = (rs1_i < rs2_i);

    assign pc_plus4 = pc_i + PC_W'(INSTR_BYTES);
    assign jalr_sum = rs1_i + imm_i;  // architectural jalr, no pc term

    // target, only low pc bits kept
    always_comb begin
        case (op_i)
            JAL, BEQ, BNE, BLT, BGE, BLTU, BGEU: begin
                target_o = pc_i + imm_i[PC_W-1:0];
            end
            JALR: begin
                target_o = {jalr_sum[PC_W-1:1], 1'b0};  // bit 0 cleared
            end
            default: begin
                target_o = '0;
            end
        endcase
    end

    always_comb begin
        case (op_i)
            JAL, JALR: taken_o = 1'b1;     // unconditional
            BEQ:       taken_o = equal;
            BNE:       taken_o = ~equal;
            BLT:       taken_o = less;
            BGE:       taken_o = ~less;
            BLTU:      taken_o = less_u;
            BGEU:      taken_o = ~less_u;
            default:   taken_o = 1'b0;     // alu ops and nop fall through
        endcase
    end

    assign next_pc_o = taken_o ? target_o : pc_plus4;
    assign link_o    = {{(XLEN-PC_W){1'b0}}, pc_plus4};  // return address, zero-extended

endmodule

//--- logic/issue_buffer.sv
// issue_buffer: two-entry in-order fifo between the input port and the execute stage
`timescale 1ns/1ps

module issue_buffer import exec_pkg::*; (
    input  logic         clk_i,
    input  logic         arst_n_i,
    input  logic         in_valid_i,
    output logic         in_ready_o,
    input  exec_req_t    in_req_i,
    exec_issue_if.src    issue
);

    exec_req_t            mem_q [BUF_DEPTH];  // entry storage
    logic [BUF_PTR_W-1:0] wr_ptr_q;
    logic [BUF_PTR_W-1:0] rd_ptr_q;
    logic [BUF_CNT_W-1:0] count_q;            // occupancy
    logic                 push;
    logic                 pop;

    // ready from occupancy only, no path back from the stage
    assign in_ready_o = (count_q != BUF_CNT_W'(BUF_DEPTH));

    assign issue.valid = (count_q != '0);  // offered right after the write edge
    assign issue.req   = mem_q[rd_ptr_q];  // head entry

    assign push = in_valid_i & in_ready_o;
    assign pop  = issue.valid & issue.ready;

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= in_req_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;  // depth is a power of two, wraps
            if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
            // push and pop together leave the count as is
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

//--- logic/exec_issue_if.sv
// valid/ready channel carrying one issued operation from buffer to execute stage
`timescale 1ns/1ps

interface exec_issue_if import exec_pkg::*; ();

    logic      valid;  // request present
    logic      ready;  // stage can take it
    exec_req_t req;    // operation payload

    // transfer on an edge with valid and ready high
    // valid and req held stable until then

    // issue_buffer side
    modport src (
        output valid,
        output req,
        input  ready
    );

    // exec_stage side
    modport dst (
        input  valid,
        input  req,
        output ready
    );

endinterface

//--- logic/exec_pkg.sv
// execute slice package: widths, buffer sizing, operation enum, issue request struct
package exec_pkg;

    localparam int XLEN        = 64;  // integer data width
    localparam int PC_W        = 40;  // virtual pc width
    localparam int REG_IDX_W   = 5;   // destination register index
    localparam int INSTR_BYTES = 4;   // fall-through step

    localparam int BUF_DEPTH = 2;                     // issue buffer entries
    localparam int BUF_PTR_W = $clog2(BUF_DEPTH);     // circular pointer
    localparam int BUF_CNT_W = $clog2(BUF_DEPTH + 1); // occupancy 0..BUF_DEPTH

    typedef logic [XLEN-1:0]      bus64_t;
    typedef logic [PC_W-1:0]      addr_pc_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // all sixteen codes in use
    typedef enum logic [3:0] {
        NOP  = 4'd0,
        JAL  = 4'd1,
        JALR = 4'd2,
        BEQ  = 4'd3,
        BNE  = 4'd4,
        BLT  = 4'd5,
        BGE  = 4'd6,
        BLTU = 4'd7,
        BGEU = 4'd8,
        ADD  = 4'd9,
        SUB  = 4'd10,
        AND  = 4'd11,
        OR   = 4'd12,
        XOR  = 4'd13,
        SLT  = 4'd14,
        SLTU = 4'd15
    } exec_op_t;

    // one issued operation, operands already read
    typedef struct packed {
        exec_op_t op;   // what to do
        addr_pc_t pc;   // pc of the instruction
        bus64_t   rs1;  // first source value
        bus64_t   rs2;  // second source value
        bus64_t   imm;  // sign-extended immediate
        reg_idx_t rd;   // destination, tags the result
    } exec_req_t;

endpackage
